//--- compile.f
+incdir+include
logic/clock_pkg.sv
logic/tick_generator.sv
logic/speed_reg_port.sv
logic/speed_switch_ctrl.sv
logic/clock_top.sv
tb/clock_top_asserts.sv
tb/clock_top_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module clock_top_tb -o clock_top_tb

run: build
	./obj_dir/clock_top_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module clock_top_tb

clean:
	rm -rf obj_dir $(LOG)

//--- tb/clock_top_tb.sv
`timescale 1ns/100ps
`include "clock_defs.svh"

module clock_top_tb;

   localparam int unsigned COUNTDOWN    = 20;
   localparam int unsigned FAST_DIV     = 32'(`CLK_FAST_DIV);
   localparam int unsigned SLOW_DIV     = 32'(`CLK_SLOW_DIV);
   localparam int unsigned PHASE_CYCLES = 1480;

   logic               I_CLK33MHZ;
   logic               I_SYNC_RESET;
   logic               I_DOUBLE_SPEED;
   clock_pkg::io_req_t io_req;
   logic [7:0]         rdata;
   logic               rd_valid;
   logic               main_tick;
   logic               dma_tick;
   logic               double_speed;
   logic               disable_controller;

   // Reference model state
   int unsigned m_cycle;        // Edges since reset release
   int unsigned m_dis_left;     // Cycles of disable_controller still to come
   logic        m_pulse;
   logic        m_double;
   logic        m_rd_valid;
   logic [7:0]  m_rdata;
   logic        checks_on;

   // Coverage of the behaviors
   int unsigned switch_count;
   int unsigned ignored_count;
   int unsigned read_hits;
   int unsigned read_misses;

   integer seed;

   clock_top #(
      .COUNTDOWN_CYCLES (COUNTDOWN)
   ) i_clock_top (
      .I_CLK33MHZ         (I_CLK33MHZ),
      .I_SYNC_RESET       (I_SYNC_RESET),
      .I_DOUBLE_SPEED     (I_DOUBLE_SPEED),
      .io_req             (io_req),
      .rdata              (rdata),
      .rd_valid           (rd_valid),
      .main_tick          (main_tick),
      .dma_tick           (dma_tick),
      .double_speed       (double_speed),
      .disable_controller (disable_controller)
   );

   always #10 I_CLK33MHZ = ~I_CLK33MHZ;   // 20 ns period

   task automatic fail_run(input string why);
      $display("Errors found");
      $display("%s", why);
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      assert (actual === expected) else begin
         fail_run($sformatf("mismatch %s expected %02h actual %02h", name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      check_value(name, {7'd0, expected}, {7'd0, actual});
   endtask

   // Cycle model, sees the inputs as the DUT samples them
   always @(posedge I_CLK33MHZ) begin : ref_model
      clock_pkg::speed_reg_u wr_view;
      clock_pkg::speed_reg_u rd_view;
      logic                  hit;
      wr_view               = io_req.wdata;
      hit                   = (io_req.addr == `CLK_SPEED_REG_ADDR);
      rd_view               = '0;
      rd_view.rd.cur_double = m_double;
      rd_view.rd.switching  = (m_dis_left != 0);
      if (I_SYNC_RESET) begin
         m_cycle    = 0;
         m_dis_left = 0;
         m_pulse    = 1'b0;
         m_double   = I_DOUBLE_SPEED;
         m_rd_valid = 1'b0;
         m_rdata    = 8'h00;
      end else begin
         m_rd_valid = io_req.re && hit;
         m_rdata    = m_rd_valid ? rd_view : 8'h00;
         if (io_req.re && hit) read_hits++;
         if (io_req.re && !hit) read_misses++;
         if (m_dis_left != 0) begin
            if (m_pulse) ignored_count++;   // Prepare during a switch
            m_dis_left--;
            if (m_dis_left == 0) begin
               m_double = ~m_double;
               switch_count++;
            end
         end else if (m_pulse) begin
            m_dis_left = COUNTDOWN + 1;
         end
         m_pulse = io_req.we && hit && wr_view.wr.prepare;
         m_cycle++;
      end
      checks_on = 1'b1;
   end

   // Compare away from the active edge
   always @(negedge I_CLK33MHZ) begin : output_checks
      logic fast_exp;
      logic slow_exp;
      if (checks_on) begin
         fast_exp = (m_cycle != 0) && ((m_cycle % FAST_DIV) == 0);
         slow_exp = (m_cycle != 0) && ((m_cycle % SLOW_DIV) == 0);
         check_bit("disable_controller", m_dis_left != 0, disable_controller);
         check_bit("double_speed", m_double, double_speed);
         check_bit("dma_tick", fast_exp, dma_tick);
         check_bit("main_tick", m_double ? fast_exp : slow_exp, main_tick);
         check_bit("rd_valid", m_rd_valid, rd_valid);
         check_value("rdata", m_rdata, rdata);
      end
   end

   task automatic apply_reset(input logic strap);
      @(posedge I_CLK33MHZ);
      I_SYNC_RESET   <= 1'b1;
      I_DOUBLE_SPEED <= strap;
      io_req         <= '0;
      repeat (3) @(posedge I_CLK33MHZ);
      I_SYNC_RESET <= 1'b0;
      @(negedge I_CLK33MHZ);
      check_bit("reset disable_controller", 1'b0, disable_controller);
      check_bit("reset rd_valid", 1'b0, rd_valid);
      check_bit("reset double_speed", strap, double_speed);
   endtask

   task automatic wait_first_tick();
      int unsigned waited;
      waited = 0;
      while (dma_tick !== 1'b1) begin
         @(negedge I_CLK33MHZ);
         waited++;
         if (waited > FAST_DIV + 2) begin
            fail_run("timeout waiting for the first DMA tick after reset");
         end
      end
   endtask

   task automatic drive_random_request();
      logic [31:0]        r;
      logic [15:0]        addr;
      clock_pkg::io_req_t req;
      r    = $random(seed);
      addr = r[2] ? `CLK_SPEED_REG_ADDR : r[31:16];
      if (!r[2] && addr == `CLK_SPEED_REG_ADDR) begin
         addr = addr ^ 16'h0001;   // Keep the miss a miss
      end
      req       = '0;
      req.addr  = addr;
      req.wdata = r[15:8];
      case (r[1:0])
         2'd1, 2'd3: req.we = 1'b1;
         2'd2:       req.re = 1'b1;
         default:    req = '0;     // Idle cycle
      endcase
      io_req <= req;
   endtask

   task automatic run_traffic(input int unsigned cycles);
      for (int unsigned i = 0; i < cycles; i++) begin
         @(posedge I_CLK33MHZ);
         drive_random_request();
      end
      @(posedge I_CLK33MHZ);
      io_req <= '0;
   endtask

   initial begin
      I_CLK33MHZ     = 1'b0;
      I_SYNC_RESET   = 1'b1;
      I_DOUBLE_SPEED = 1'b0;
      io_req         = '0;
      checks_on      = 1'b0;
      switch_count   = 0;
      ignored_count  = 0;
      read_hits      = 0;
      read_misses    = 0;
      seed           = 32'h15e0_0e86;

      apply_reset(1'b0);
      wait_first_tick();
      run_traffic(PHASE_CYCLES);

      // Second start-up with the double speed strap
      apply_reset(1'b1);
      wait_first_tick();
      run_traffic(PHASE_CYCLES);

      assert (switch_count >= 4) else fail_run("too few speed switches took place");
      assert (ignored_count > 0) else fail_run("no prepare write hit a running switch");
      assert (read_hits > 0) else fail_run("the speed register was never read");
      assert (read_misses > 0) else fail_run("no read went to another address");
      $display("No errors");
      $finish;
   end

endmodule

//--- tb/clock_top_asserts.sv
`timescale 1ns/100ps

module clock_top_asserts (
   input logic                  I_CLK33MHZ,
   input logic                  I_SYNC_RESET,
   input logic                  io_re,
   input clock_pkg::clk_ticks_t ticks,
   input logic                  rd_valid,
   input logic                  double_speed,
   input logic                  disable_controller
);

   // Slow period is a multiple of the fast one
   slow_implies_fast: assert property (@(posedge I_CLK33MHZ) disable iff (I_SYNC_RESET)
      ticks.slow |-> ticks.fast)
      else $error("slow tick seen without a fast tick");

   // Speed only moves when the controller is released
   speed_change_at_release: assert property (@(posedge I_CLK33MHZ) disable iff (I_SYNC_RESET)
      $changed(double_speed) |-> $fell(disable_controller))
      else $error("double_speed changed outside the end of a switch");

   // Back-to-back read data needs back-to-back reads
   rd_valid_needs_reads: assert property (@(posedge I_CLK33MHZ) disable iff (I_SYNC_RESET)
      (rd_valid && $past(rd_valid)) |-> ($past(io_re) && $past(io_re, 2)))
      else $error("rd_valid high twice without two reads");

endmodule

bind clock_top clock_top_asserts i_clock_top_asserts (
   .I_CLK33MHZ         (I_CLK33MHZ),
   .I_SYNC_RESET       (I_SYNC_RESET),
   .io_re              (io_req.re),
   .ticks              (ticks),
   .rd_valid           (rd_valid),
   .double_speed       (double_speed),
   .disable_controller (disable_controller)
);

//--- logic/clock_top.sv
`timescale 1ns/100ps
`include "clock_defs.svh"

module clock_top #(
   parameter int unsigned COUNTDOWN_CYCLES = `CLK_DEFAULT_COUNTDOWN
) (
   input  logic               I_CLK33MHZ,
   input  logic               I_SYNC_RESET,
   input  logic               I_DOUBLE_SPEED,
   input  clock_pkg::io_req_t io_req,
   output logic [7:0]         rdata,
   output logic               rd_valid,
   output logic               main_tick,
   output logic               dma_tick,
   output logic               double_speed,
   output logic               disable_controller
);

   clock_pkg::clk_ticks_t    ticks;
   clock_pkg::speed_status_t status;
   logic                     prepare_pulse;   // Register port to switch FSM

   tick_generator i_tick_generator (
      .I_CLK33MHZ   (I_CLK33MHZ),
      .I_SYNC_RESET (I_SYNC_RESET),
      .ticks        (ticks)
   );

   speed_reg_port i_speed_reg_port (
      .I_CLK33MHZ    (I_CLK33MHZ),
      .I_SYNC_RESET  (I_SYNC_RESET),
      .req           (io_req),
      .status        (status),
      .prepare_pulse (prepare_pulse),
      .rdata         (rdata),
      .rd_valid      (rd_valid)
   );

   speed_switch_ctrl #(
      .COUNTDOWN_CYCLES (COUNTDOWN_CYCLES)
   ) i_speed_switch_ctrl (
      .I_CLK33MHZ         (I_CLK33MHZ),
      .I_SYNC_RESET       (I_SYNC_RESET),
      .I_DOUBLE_SPEED     (I_DOUBLE_SPEED),
      .prepare_pulse      (prepare_pulse),
      .ticks              (ticks),
      .status             (status),
      .main_tick          (main_tick),
      .dma_tick           (dma_tick),
      .double_speed       (double_speed),
      .disable_controller (disable_controller)
   );

endmodule

//--- logic/speed_switch_ctrl.sv
`timescale 1ns/100ps
`include "clock_defs.svh"

module speed_switch_ctrl #(
   parameter int unsigned COUNTDOWN_CYCLES = `CLK_DEFAULT_COUNTDOWN
) (
   input  logic                     I_CLK33MHZ,
   input  logic                     I_SYNC_RESET,
   input  logic                     I_DOUBLE_SPEED,
   input  logic                     prepare_pulse,
   input  clock_pkg::clk_ticks_t    ticks,
   output clock_pkg::speed_status_t status,
   output logic                     main_tick,
   output logic                     dma_tick,
   output logic                     double_speed,
   output logic                     disable_controller
);

   localparam logic [`CLK_COUNT_W-1:0] COUNT_LOAD = `CLK_COUNT_W'(COUNTDOWN_CYCLES);
   localparam logic [`CLK_COUNT_W-1:0] COUNT_STEP = `CLK_COUNT_W'(1);

   typedef enum logic {
      ST_IDLE,
      ST_COUNTING
   } state_t;

   state_t                  state;
   state_t                  state_nxt;
   logic [`CLK_COUNT_W-1:0] count;
   logic                    count_done;

   assign count_done = (count == '0);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (prepare_pulse) begin
               state_nxt = ST_COUNTING;
            end
         end
         ST_COUNTING: begin
            // New prepares are dropped here until the switch is over
            if (count_done) begin
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge I_CLK33MHZ) begin
      if (I_SYNC_RESET) begin
         state        <= ST_IDLE;
         count        <= '0;
         double_speed <= I_DOUBLE_SPEED;   // Strap picks the start-up speed
      end else begin
         state <= state_nxt;
         if (state == ST_IDLE && prepare_pulse) begin
            count <= COUNT_LOAD;
         end else if (state == ST_COUNTING && !count_done) begin
            count <= count - COUNT_STEP;
         end
         // Speed flips on the same edge the controller is released
         if (state == ST_COUNTING && count_done) begin
            double_speed <= ~double_speed;
         end
      end
   end

   // High for COUNTDOWN_CYCLES+1 cycles as the count runs down to zero inclusive
   assign disable_controller = (state == ST_COUNTING);

   assign status.double_speed = double_speed;
   assign status.switching    = disable_controller;

   // Tick select follows the speed flag
   assign main_tick = double_speed ? ticks.fast : ticks.slow;
   assign dma_tick  = ticks.fast;                          // DMA always at the fast rate

endmodule

//--- logic/speed_reg_port.sv
`timescale 1ns/100ps
`include "clock_defs.svh"

module speed_reg_port (
   input  logic                     I_CLK33MHZ,
   input  logic                     I_SYNC_RESET,
   input  clock_pkg::io_req_t       req,
   input  clock_pkg::speed_status_t status,
   output logic                     prepare_pulse,
   output logic [7:0]               rdata,
   output logic                     rd_valid
);

   clock_pkg::speed_reg_u wr_byte;
   clock_pkg::speed_reg_u rd_byte;
   logic                  addr_hit;
   logic                  wr_prepare;
   logic                  rd_hit;

   assign addr_hit = (req.addr == `CLK_SPEED_REG_ADDR);

   // Write side, only bit 0 means anything
   assign wr_byte    = req.wdata;
   assign wr_prepare = req.we & addr_hit & wr_byte.wr.prepare;

   assign rd_hit = req.re & addr_hit;

   // Status byte as the CPU sees it
   always_comb begin
      rd_byte.rd.cur_double = status.double_speed;
      rd_byte.rd.rsvd       = '0;
      rd_byte.rd.switching  = status.switching;
   end

   // Writes are always accepted
   // A prepare gives one pulse on the next edge
   always_ff @(posedge I_CLK33MHZ) begin
      if (I_SYNC_RESET) begin
         prepare_pulse <= 1'b0;
      end else begin
         prepare_pulse <= wr_prepare;
      end
   end

   // Fixed one-cycle read latency
   always_ff @(posedge I_CLK33MHZ) begin
      if (I_SYNC_RESET) begin
         rd_valid <= 1'b0;
         rdata    <= 8'h00;
      end else begin
         rd_valid <= rd_hit;
         rdata    <= rd_hit ? rd_byte : 8'h00;   // Zero unless our register is read
      end
   end

endmodule

//--- logic/tick_generator.sv
`timescale 1ns/100ps
`include "clock_defs.svh"

module tick_generator (
   input  logic                  I_CLK33MHZ,
   input  logic                  I_SYNC_RESET,
   output clock_pkg::clk_ticks_t ticks
);

   localparam logic [4:0] SLOW_LAST = `CLK_SLOW_DIV - 5'd1;
   localparam logic [4:0] FAST_DIV  = 5'(`CLK_FAST_DIV);
   localparam logic [4:0] FAST_LAST = FAST_DIV - 5'd1;

   logic [4:0] div_cnt;
   logic       fast_hit;
   logic       slow_hit;

   // Decode on the current count, the tick shows up one cycle later
   assign slow_hit = (div_cnt == SLOW_LAST);
   assign fast_hit = ((div_cnt % FAST_DIV) == FAST_LAST);

   // Free-running divider, one period per slow tick
   always_ff @(posedge I_CLK33MHZ) begin
      if (I_SYNC_RESET) begin
         div_cnt <= '0;
      end else if (slow_hit) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 5'd1;
      end
   end

   // Registered enables
   // Each is high for one cycle at the end of its period
   always_ff @(posedge I_CLK33MHZ) begin
      if (I_SYNC_RESET) begin
         ticks <= '0;
      end else begin
         ticks.fast <= fast_hit;
         ticks.slow <= slow_hit;   // Implies fast_hit as FAST_DIV divides SLOW_DIV
      end
   end

endmodule

//--- logic/clock_pkg.sv
package clock_pkg;

   // One request on the IO register bus
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        we;       // Single-cycle write strobe
      logic        re;       // Read strobe, data back one cycle later
   } io_req_t;

   // Clock-enable ticks from the divider
   typedef struct packed {
      logic fast;
      logic slow;            // Always coincides with fast
   } clk_ticks_t;

   typedef struct packed {
      logic double_speed;
      logic switching;       // Countdown running, controller held off
   } speed_status_t;

   // The speed register byte means different things on write and read
   typedef union packed {
      struct packed {
         logic [6:0] rsvd;
         logic       prepare;      // Arms a speed switch
      } wr;
      struct packed {
         logic       cur_double;   // Current speed
         logic [5:0] rsvd;
         logic       switching;
      } rd;
   } speed_reg_u;

endpackage

//--- include/clock_defs.svh
`ifndef CLOCK_DEFS_SVH
`define CLOCK_DEFS_SVH

// Speed register location on the IO bus
`define CLK_SPEED_REG_ADDR 16'hFF4D

// Cycles of I_CLK33MHZ between slow ticks (normal speed)
`define CLK_SLOW_DIV 5'd16

// Cycles between fast ticks (double speed and DMA)
// Has to divide CLK_SLOW_DIV so that slow ticks land on fast ones
`define CLK_FAST_DIV 4'd8

// Width of the switch countdown counter
`define CLK_COUNT_W 16

// Cycles the controller is held off before a speed change
`define CLK_DEFAULT_COUNTDOWN 255

`endif
